//--- common/debug_pkg.sv
package debug_pkg;

    localparam int WORD_W         = 32;
    localparam int BYTE_W         = 8;
    localparam int BYTES_PER_WORD = WORD_W / BYTE_W;

    localparam int NUM_REGS       = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int NUM_DMEM_WORDS = 16;
    localparam int DMEM_ADDR_W    = 4;
    localparam int IMEM_ADDR_W    = 8;

    // PC, cycle count, registers, data memory
    localparam int DUMP_WORDS     = 2 + NUM_REGS + NUM_DMEM_WORDS;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BYTE_W-1:0] link_byte_t;

    localparam link_byte_t CMD_RUN  = 8'h63;    // 'c'
    localparam link_byte_t CMD_STEP = 8'h73;    // 's'
    localparam link_byte_t CMD_NEXT = 8'h6e;    // 'n'
    localparam link_byte_t CMD_LOAD = 8'h64;    // 'd'

    localparam word_t HALT_WORD = '1;           // End of program marker

    typedef struct packed {
        word_t word;
        logic  last;                            // Final word of a dump
    } dump_word_t;

    typedef enum logic [2:0] {
        IDLE,
        RUN,
        STEP_WAIT,
        STEP_PULSE,
        LOAD,
        DUMP,
        DUMP_WAIT
    } ctrl_state_t;

endpackage

//--- common/word_stream_if.sv
interface word_stream_if;
    import debug_pkg::*;

    logic  valid;
    logic  ready;
    word_t word;
    logic  last;

    modport source (
        output valid,
        output word,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  word,
        input  last,
        output ready
    );

endinterface

//--- hw/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_valid,
    output logic     o_ready,
    input  payload_t i_data,
    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    logic     full_q;
    logic     live_q;                       // Low for the first cycle out of reset
    payload_t data_q;

    assign o_ready = live_q && (!full_q || i_ready);
    assign o_valid = full_q;
    assign o_data  = data_q;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            full_q <= 1'b0;
            live_q <= 1'b0;
        end
        else
        begin
            live_q <= 1'b1;
            if (o_ready)
                full_q <= i_valid;          // Refill or drain
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid && o_ready)
            data_q <= i_data;
    end

endmodule

//--- control/debug_cmd_ctrl.sv
module debug_cmd_ctrl (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_byte_valid,
    output logic                  o_byte_ready,
    input  debug_pkg::link_byte_t i_byte,
    input  logic                  i_halt,
    output logic                  o_cpu_run,
    output logic                  o_load_valid,
    output debug_pkg::link_byte_t o_load_byte,
    input  logic                  i_load_done,
    output logic                  o_dump_start,
    input  logic                  i_dump_done
);
    import debug_pkg::*;

    ctrl_state_t state_q;
    logic        step_mode_q;
    logic        halt_seen_q;
    logic        accept;

    always_comb
    begin
        case (state_q)
            IDLE:      o_byte_ready = 1'b1;
            STEP_WAIT: o_byte_ready = !i_halt;          // Halt wins over a pending 'n'
            LOAD:      o_byte_ready = !i_load_done;     // Stop at the end of the program
            default:   o_byte_ready = 1'b0;
        endcase
    end

    assign accept       = i_byte_valid && o_byte_ready;
    assign o_cpu_run    = (state_q == RUN) || (state_q == STEP_PULSE);
    assign o_load_valid = accept && (state_q == LOAD);
    assign o_load_byte  = i_byte;
    assign o_dump_start = (state_q == DUMP);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state_q     <= IDLE;
            step_mode_q <= 1'b0;
            halt_seen_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    halt_seen_q <= 1'b0;
                    if (accept)
                    begin
                        case (i_byte)
                            CMD_RUN:  state_q <= RUN;
                            CMD_LOAD: state_q <= LOAD;
                            CMD_STEP:
                            begin
                                state_q     <= STEP_WAIT;
                                step_mode_q <= 1'b1;
                            end
                            default:  state_q <= IDLE;  // Unknown byte dropped
                        endcase
                    end
                end
                RUN:
                begin
                    if (i_halt)
                    begin
                        state_q     <= DUMP;
                        halt_seen_q <= 1'b1;
                    end
                end
                STEP_WAIT:
                begin
                    if (i_halt)
                    begin
                        state_q     <= DUMP;
                        halt_seen_q <= 1'b1;
                    end
                    else if (accept && i_byte == CMD_NEXT)
                        state_q <= STEP_PULSE;
                end
                STEP_PULSE:
                begin
                    state_q <= DUMP;                    // Exactly one enabled cycle
                    if (i_halt)
                        halt_seen_q <= 1'b1;
                end
                LOAD:
                begin
                    if (i_load_done)
                        state_q <= IDLE;
                end
                DUMP:
                    state_q <= DUMP_WAIT;
                DUMP_WAIT:
                begin
                    if (i_dump_done)
                    begin
                        if (step_mode_q && !halt_seen_q)
                            state_q <= STEP_WAIT;
                        else
                        begin
                            state_q     <= IDLE;
                            step_mode_q <= 1'b0;
                        end
                    end
                end
                default:
                    state_q <= IDLE;
            endcase
        end
    end

endmodule

//--- control/instr_loader.sv
module instr_loader (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_load_valid,
    input  debug_pkg::link_byte_t             i_load_byte,
    output logic                              o_load_done,
    output logic                              o_imem_we,
    output logic [debug_pkg::IMEM_ADDR_W-1:0] o_imem_addr,
    output debug_pkg::word_t                  o_imem_data
);
    import debug_pkg::*;

    logic [$clog2(BYTES_PER_WORD)-1:0] count_q;
    logic [IMEM_ADDR_W-1:0]            addr_q;
    word_t                             word_q;
    word_t                             word_next;

    assign word_next   = {word_q[WORD_W-BYTE_W-1:0], i_load_byte};    // MSB first
    assign o_imem_addr = addr_q;
    assign o_imem_data = word_q;

    always_ff @(posedge i_clk)
    begin
        if (i_load_valid)
            word_q <= word_next;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            count_q     <= '0;
            addr_q      <= '0;
            o_imem_we   <= 1'b0;
            o_load_done <= 1'b0;
        end
        else
        begin
            o_imem_we   <= 1'b0;
            o_load_done <= 1'b0;

            if (i_load_valid)
            begin
                count_q <= count_q + 1'b1;
                if (count_q == BYTES_PER_WORD - 1)
                begin
                    o_imem_we   <= 1'b1;
                    o_load_done <= (word_next == HALT_WORD);
                end
            end

            // Advance after the write, restart at 0 once HALT is stored
            if (o_imem_we)
                addr_q <= (word_q == HALT_WORD) ? '0 : addr_q + IMEM_ADDR_W'(BYTES_PER_WORD);
        end
    end

endmodule

//--- dump/dump_sequencer.sv
module dump_sequencer (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_start,
    input  debug_pkg::word_t                  i_pc,
    input  debug_pkg::word_t                  i_cycle_count,
    output logic [debug_pkg::REG_ADDR_W-1:0]  o_reg_addr,
    input  debug_pkg::word_t                  i_reg_data,
    output logic [debug_pkg::DMEM_ADDR_W-1:0] o_dmem_addr,
    input  debug_pkg::word_t                  i_dmem_data,
    word_stream_if.source                     o_words
);
    import debug_pkg::*;

    typedef enum logic [1:0] {PH_PC, PH_CYCLE, PH_REG, PH_DMEM} phase_t;

    phase_t                          phase_q;
    logic                            active_q;
    logic [$clog2(DUMP_WORDS)-1:0]   idx_q;
    logic [REG_ADDR_W-1:0]           reg_addr_q;
    logic [DMEM_ADDR_W-1:0]          dmem_addr_q;
    logic                            take;

    assign take        = o_words.valid && o_words.ready;
    assign o_reg_addr  = reg_addr_q;
    assign o_dmem_addr = dmem_addr_q;

    assign o_words.valid = active_q;
    assign o_words.last  = (idx_q == DUMP_WORDS - 1);

    always_comb
    begin
        case (phase_q)
            PH_PC:    o_words.word = i_pc;
            PH_CYCLE: o_words.word = i_cycle_count;
            PH_REG:   o_words.word = i_reg_data;      // Read data matches reg_addr_q
            default:  o_words.word = i_dmem_data;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            active_q    <= 1'b0;
            phase_q     <= PH_PC;
            idx_q       <= '0;
            reg_addr_q  <= '0;
            dmem_addr_q <= '0;
        end
        else if (i_start)
        begin
            active_q    <= 1'b1;
            phase_q     <= PH_PC;
            idx_q       <= '0;
            reg_addr_q  <= '0;
            dmem_addr_q <= '0;
        end
        else if (take)
        begin
            idx_q <= idx_q + 1'b1;
            case (phase_q)
                PH_PC:    phase_q <= PH_CYCLE;
                PH_CYCLE: phase_q <= PH_REG;
                PH_REG:
                begin
                    if (reg_addr_q == REG_ADDR_W'(NUM_REGS - 1))
                        phase_q <= PH_DMEM;
                    else
                        reg_addr_q <= reg_addr_q + 1'b1;
                end
                default:
                begin
                    if (o_words.last)
                        active_q <= 1'b0;
                    else
                        dmem_addr_q <= dmem_addr_q + 1'b1;
                end
            endcase
        end
    end

endmodule

//--- dump/word_serializer.sv
module word_serializer (
    input  logic                  i_clk,
    input  logic                  i_reset,
    word_stream_if.sink           i_words,
    output logic                  o_tx_valid,
    output debug_pkg::link_byte_t o_tx_data,
    input  logic                  i_tx_ready,
    output logic                  o_dump_done
);
    import debug_pkg::*;

    logic [$clog2(BYTES_PER_WORD)-1:0] cnt_q;
    word_t                             word_q;
    logic                              last_q;
    logic                              busy_q;

    assign i_words.ready = !busy_q;
    assign o_tx_valid    = busy_q;
    assign o_tx_data     = word_q[WORD_W-1-cnt_q*BYTE_W -: BYTE_W];   // MSB first

    always_ff @(posedge i_clk)
    begin
        if (i_words.valid && i_words.ready)
        begin
            word_q <= i_words.word;
            last_q <= i_words.last;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            busy_q      <= 1'b0;
            cnt_q       <= '0;
            o_dump_done <= 1'b0;
        end
        else
        begin
            o_dump_done <= 1'b0;
            if (i_words.valid && i_words.ready)
            begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end
            else if (busy_q && i_tx_ready)
            begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == BYTES_PER_WORD - 1)
                begin
                    busy_q      <= 1'b0;
                    o_dump_done <= last_q;
                end
            end
        end
    end

endmodule

//--- hw/debug_unit_top.sv
module debug_unit_top (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_rx_valid,
    input  debug_pkg::link_byte_t             i_rx_data,
    output logic                              o_rx_ready,
    output logic                              o_tx_valid,
    output debug_pkg::link_byte_t             o_tx_data,
    input  logic                              i_tx_ready,
    output logic                              o_cpu_run,
    input  logic                              i_halt,
    input  debug_pkg::word_t                  i_pc,
    input  debug_pkg::word_t                  i_cycle_count,
    output logic [debug_pkg::REG_ADDR_W-1:0]  o_reg_addr,
    input  debug_pkg::word_t                  i_reg_data,
    output logic [debug_pkg::DMEM_ADDR_W-1:0] o_dmem_addr,
    input  debug_pkg::word_t                  i_dmem_data,
    output logic                              o_imem_we,
    output logic [debug_pkg::IMEM_ADDR_W-1:0] o_imem_addr,
    output debug_pkg::word_t                  o_imem_data
);
    import debug_pkg::*;

    logic       cmd_valid;
    logic       cmd_ready;
    link_byte_t cmd_byte;
    logic       load_valid;
    link_byte_t load_byte;
    logic       load_done;
    logic       dump_start;
    logic       dump_done;
    dump_word_t seq_word;
    dump_word_t ser_word;

    word_stream_if seq_if ();
    word_stream_if ser_if ();

    stage_reg #(.payload_t(link_byte_t)) u_rx_stage (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_rx_valid),
        .o_ready (o_rx_ready),
        .i_data  (i_rx_data),
        .o_valid (cmd_valid),
        .i_ready (cmd_ready),
        .o_data  (cmd_byte)
    );

    debug_cmd_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_byte_valid (cmd_valid),
        .o_byte_ready (cmd_ready),
        .i_byte       (cmd_byte),
        .i_halt       (i_halt),
        .o_cpu_run    (o_cpu_run),
        .o_load_valid (load_valid),
        .o_load_byte  (load_byte),
        .i_load_done  (load_done),
        .o_dump_start (dump_start),
        .i_dump_done  (dump_done)
    );

    instr_loader u_loader (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_load_valid (load_valid),
        .i_load_byte  (load_byte),
        .o_load_done  (load_done),
        .o_imem_we    (o_imem_we),
        .o_imem_addr  (o_imem_addr),
        .o_imem_data  (o_imem_data)
    );

    dump_sequencer u_seq (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_start       (dump_start),
        .i_pc          (i_pc),
        .i_cycle_count (i_cycle_count),
        .o_reg_addr    (o_reg_addr),
        .i_reg_data    (i_reg_data),
        .o_dmem_addr   (o_dmem_addr),
        .i_dmem_data   (i_dmem_data),
        .o_words       (seq_if.source)
    );

    // Word stage between the stream interfaces
    assign seq_word.word = seq_if.word;
    assign seq_word.last = seq_if.last;
    assign ser_if.word   = ser_word.word;
    assign ser_if.last   = ser_word.last;

    stage_reg #(.payload_t(dump_word_t)) u_word_stage (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (seq_if.valid),
        .o_ready (seq_if.ready),
        .i_data  (seq_word),
        .o_valid (ser_if.valid),
        .i_ready (ser_if.ready),
        .o_data  (ser_word)
    );

    word_serializer u_ser (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_words     (ser_if.sink),
        .o_tx_valid  (o_tx_valid),
        .o_tx_data   (o_tx_data),
        .i_tx_ready  (i_tx_ready),
        .o_dump_done (dump_done)
    );

endmodule

//--- verif/debug_unit_chk.sv
module debug_unit_chk (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              o_tx_valid,
    input  debug_pkg::link_byte_t             o_tx_data,
    input  logic                              i_tx_ready,
    input  logic                              o_imem_we,
    input  logic [debug_pkg::IMEM_ADDR_W-1:0] o_imem_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failures = 0;                  // Read by the testbench at the end

    a_tx_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_data)))
    else
    begin
        $error("tx byte dropped or changed while waiting for ready");
        failures++;
    end

    a_imem_align: assert property (@(posedge i_clk) disable iff (i_reset)
        o_imem_we |-> (o_imem_addr[1:0] == 2'b00))
    else
    begin
        $error("instruction write to an unaligned address");
        failures++;
    end

    a_reset_quiet: assert property (@(posedge i_clk)
        i_reset |=> (!o_imem_we && !o_tx_valid))
    else
    begin
        $error("write or tx strobe high right after reset");
        failures++;
    end

endmodule

bind debug_unit_top debug_unit_chk u_chk (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .o_tx_valid  (o_tx_valid),
    .o_tx_data   (o_tx_data),
    .i_tx_ready  (i_tx_ready),
    .o_imem_we   (o_imem_we),
    .o_imem_addr (o_imem_addr)
);

//--- verif/tb_debug_unit.sv
module tb_debug_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import debug_pkg::*;

    localparam int MAX_LOAD_WORDS = 8;
    localparam int NUM_STEPS      = 4;
    localparam int NUM_PIPED      = 3;          // 'n' bytes sent back to back
    localparam int NUM_UNKNOWN    = 6;
    localparam int DUMP_BYTES     = DUMP_WORDS * BYTES_PER_WORD;
    localparam int NUM_DUMPS      = 1 + NUM_STEPS + NUM_PIPED + 1;
    localparam int BYTES_DRIVEN   = 2 * (1 + BYTES_PER_WORD * (MAX_LOAD_WORDS + 1))
                                    + 2 + NUM_STEPS + NUM_PIPED + NUM_UNKNOWN;
    localparam int TIMEOUT_CYCLES = 8 * (BYTES_DRIVEN + NUM_DUMPS * DUMP_BYTES) + 200;

    logic                   i_clk;
    logic                   i_reset;
    logic                   i_rx_valid;
    link_byte_t             i_rx_data;
    logic                   o_rx_ready;
    logic                   o_tx_valid;
    link_byte_t             o_tx_data;
    logic                   i_tx_ready;
    logic                   o_cpu_run;
    logic                   i_halt;
    word_t                  i_pc;
    word_t                  i_cycle_count;
    logic [REG_ADDR_W-1:0]  o_reg_addr;
    word_t                  i_reg_data;
    logic [DMEM_ADDR_W-1:0] o_dmem_addr;
    word_t                  i_dmem_data;
    logic                   o_imem_we;
    logic [IMEM_ADDR_W-1:0] o_imem_addr;
    word_t                  o_imem_data;

    word_t                  regs [NUM_REGS];
    word_t                  dmem [NUM_DMEM_WORDS];
    logic                   ready_pat [1024];
    link_byte_t             tx_q [$];
    logic [IMEM_ADDR_W-1:0] wr_addr_q [$];
    word_t                  wr_data_q [$];
    int                     cycles = 0;
    int                     run_cycles = 0;
    int                     tx_total = 0;
    int                     checks = 0;
    int                     errors = 0;

    assign i_reg_data  = regs[o_reg_addr];      // Combinational CPU-side reads
    assign i_dmem_data = dmem[o_dmem_addr];

    debug_unit_top dut (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(negedge i_clk)
        i_tx_ready = ready_pat[cycles % 1024];

    // Collect everything the DUT puts out
    always @(posedge i_clk)
    begin
        cycles++;
        if (!i_reset)
        begin
            if (o_tx_valid && i_tx_ready)
            begin
                tx_q.push_back(o_tx_data);
                tx_total++;
            end
            if (o_imem_we)
            begin
                wr_addr_q.push_back(o_imem_addr);
                wr_data_q.push_back(o_imem_data);
            end
            if (o_cpu_run)
                run_cycles++;
        end
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic randomize_state();
        for (int k = 0; k < NUM_REGS; k++)
            regs[k] = $urandom;
        for (int k = 0; k < NUM_DMEM_WORDS; k++)
            dmem[k] = $urandom;
        i_pc          = $urandom;
        i_cycle_count = $urandom;
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_byte(input link_byte_t b);
        i_rx_valid = 1'b1;
        i_rx_data  = b;
        do
            @(posedge i_clk);
        while (!o_rx_ready);
        @(negedge i_clk);
        i_rx_valid = 1'b0;
    endtask

    task automatic send_word(input word_t w);
        for (int b = BYTES_PER_WORD - 1; b >= 0; b--)
            send_byte(w[b*BYTE_W +: BYTE_W]);      // MSB first
    endtask

    task automatic wait_bytes(input int n);
        while (tx_q.size() < n)
            @(negedge i_clk);
    endtask

    // Expected dump order is PC, cycle count, registers, data memory
    task automatic check_dump(input string name);
        word_t      exp_words [DUMP_WORDS];
        link_byte_t exp_byte;
        exp_words[0] = i_pc;
        exp_words[1] = i_cycle_count;
        for (int k = 0; k < NUM_REGS; k++)
            exp_words[2+k] = regs[k];
        for (int k = 0; k < NUM_DMEM_WORDS; k++)
            exp_words[2+NUM_REGS+k] = dmem[k];
        wait_bytes(DUMP_BYTES);
        for (int k = 0; k < DUMP_BYTES; k++)
        begin
            exp_byte = exp_words[k/4][WORD_W-1-8*(k%4) -: BYTE_W];
            compare_value($sformatf("%s byte %0d", name, k), exp_byte, tx_q.pop_front());
        end
    endtask

    task automatic load_program(input string name);
        word_t words [$];
        word_t w;
        int    n;
        n = 1 + $urandom % MAX_LOAD_WORDS;
        for (int k = 0; k < n; k++)
        begin
            w = $urandom;
            if (w == HALT_WORD)
                w = '0;                             // Keep the end marker unique
            words.push_back(w);
        end
        words.push_back(HALT_WORD);
        wr_addr_q.delete();
        wr_data_q.delete();
        send_byte(CMD_LOAD);
        for (int k = 0; k < words.size(); k++)
            send_word(words[k]);
        while (wr_addr_q.size() < words.size())
            @(negedge i_clk);
        repeat (4) @(negedge i_clk);
        compare_value({name, " write count"}, words.size(), wr_addr_q.size());
        for (int k = 0; k < words.size(); k++)
        begin
            compare_value($sformatf("%s addr %0d", name, k), 4 * k, wr_addr_q[k]);
            compare_value($sformatf("%s data %0d", name, k), words[k], wr_data_q[k]);
        end
    endtask

    task automatic run_test();
        int hold;
        randomize_state();
        hold = 4 + $urandom % 16;
        send_byte(CMD_RUN);
        @(negedge i_clk);
        compare_value("run start", 1, o_cpu_run);
        repeat (hold)
        begin
            @(negedge i_clk);
            compare_value("run enable", 1, o_cpu_run);
        end
        i_halt = 1'b1;
        @(negedge i_clk);
        i_halt = 1'b0;
        compare_value("run stop", 0, o_cpu_run);
        check_dump("run dump");
    endtask

    task automatic step_test();
        int runs;
        send_byte(CMD_STEP);
        repeat (4) @(negedge i_clk);
        compare_value("step idle enable", 0, o_cpu_run);
        for (int s = 0; s < NUM_STEPS; s++)
        begin
            randomize_state();                      // New CPU state between dumps
            runs = run_cycles;
            send_byte(CMD_NEXT);
            check_dump($sformatf("step %0d dump", s));
            compare_value($sformatf("step %0d run cycles", s), runs + 1, run_cycles);
        end
        // Later bytes wait in the byte stage and at the port during the dumps
        randomize_state();
        runs = run_cycles;
        for (int s = 0; s < NUM_PIPED; s++)
            send_byte(CMD_NEXT);
        for (int s = 0; s < NUM_PIPED; s++)
            check_dump($sformatf("queued step %0d dump", s));
        compare_value("queued steps run cycles", runs + NUM_PIPED, run_cycles);
        randomize_state();
        runs = run_cycles;
        i_halt = 1'b1;                              // Held until the final dump begins
        while (!o_tx_valid)
            @(negedge i_clk);
        i_halt = 1'b0;
        check_dump("step halt dump");
        compare_value("step halt run cycles", runs, run_cycles);
    endtask

    task automatic unknown_test();
        link_byte_t b;
        int         runs;
        int         txn;
        runs = run_cycles;
        txn  = tx_total;
        wr_addr_q.delete();
        send_byte(CMD_NEXT);                        // Only meaningful in step mode
        for (int k = 1; k < NUM_UNKNOWN; k++)
        begin
            do
                b = $urandom;
            while (b == CMD_RUN || b == CMD_STEP || b == CMD_LOAD);
            send_byte(b);
        end
        repeat (20) @(negedge i_clk);
        compare_value("unknown writes", 0, wr_addr_q.size());
        compare_value("unknown run cycles", runs, run_cycles);
        compare_value("unknown tx bytes", txn, tx_total);
        compare_value("leftover tx bytes", 0, tx_q.size());
    endtask

    initial
    begin
        void'($urandom(32'h910));
        i_reset    = 1'b1;
        i_rx_valid = 1'b0;
        i_rx_data  = '0;
        i_tx_ready = 1'b0;
        i_halt     = 1'b0;
        for (int k = 0; k < 1024; k++)
            ready_pat[k] = ($urandom % 3) != 0;     // Roughly one stall in three
        randomize_state();
        repeat (8) @(negedge i_clk);
        i_reset = 1'b0;
        compare_value("reset tx valid", 0, o_tx_valid);
        compare_value("reset imem we", 0, o_imem_we);
        compare_value("reset cpu run", 0, o_cpu_run);
        compare_value("reset rx ready", 0, o_rx_ready);
        @(negedge i_clk);
        compare_value("rx ready after reset", 1, o_rx_ready);

        load_program("load first");
        load_program("load repeat");
        run_test();
        step_test();
        unknown_test();

        errors += dut.u_chk.failures;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut.u_chk.failures);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- mips_debug.f
common/debug_pkg.sv
common/word_stream_if.sv
hw/stage_reg.sv
control/debug_cmd_ctrl.sv
control/instr_loader.sv
dump/dump_sequencer.sv
dump/word_serializer.sv
hw/debug_unit_top.sv
verif/debug_unit_chk.sv
verif/tb_debug_unit.sv
